// ==== Bender.yml ====
package:
  name: udp_parser

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/udp_parser_pkg.sv
      - rtl/frame_reader.sv
      - rtl/header_extractor.sv
      - rtl/udp_checksum.sv
      - rtl/payload_fifo.sv
      - rtl/udp_parser.sv
  - target: test
    files:
      - tests/tb_udp_parser.sv

// ==== rtl/frame_reader.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_reader (
    input  wire                         clock,
    input  wire                         reset,
    input  wire udp_parser_pkg::byte_t  in_data,
    input  wire                         in_sof,
    input  wire                         in_eof,
    input  wire                         in_empty,
    output logic                        in_rd_en,
    output logic                        beat_valid,
    output udp_parser_pkg::byte_t       beat_data,
    input  wire                         beat_ready,
    input  wire                         frame_end
);

    typedef enum logic [1:0] {HUNT, PASS, SKIP} state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= HUNT;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        beat_valid = 1'b0;
        in_rd_en   = 1'b0;
        case (state)
            HUNT: begin
                // sof byte goes on, everything else is dropped
                if (!in_empty && in_sof) begin
                    beat_valid = 1'b1;
                    in_rd_en   = beat_ready;
                    if (beat_ready) begin
                        state_next = PASS;
                    end
                end else begin
                    in_rd_en = !in_empty;
                end
            end
            PASS: begin
                beat_valid = !in_empty;
                in_rd_en   = beat_valid && beat_ready;
                if (in_rd_en && frame_end) begin
                    // no trailer means the last payload byte is the eof byte
                    state_next = in_eof ? HUNT : SKIP;
                end
            end
            SKIP: begin
                // drain trailer through eof
                in_rd_en = !in_empty;
                if (!in_empty && in_eof) begin
                    state_next = HUNT;
                end
            end
            default: begin
                state_next = HUNT;
            end
        endcase
    end

    assign beat_data = in_data;

    // eof inside the parsed region means the udp length disagrees with the frame
    assert property (@(posedge clock) disable iff (reset)
        state == PASS && in_rd_en && in_eof |-> frame_end)
        else $error("eof seen before the end of the udp payload");

endmodule

`default_nettype wire

// ==== rtl/header_extractor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "udp_parser_defines.svh"

module header_extractor (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             beat_valid,
    input  wire udp_parser_pkg::byte_t      beat_data,
    output logic                            beat_ready,
    output logic                            frame_end,
    output udp_parser_pkg::csum_beat_t      csum_beat,
    output logic                            pay_valid,
    output udp_parser_pkg::byte_t           pay_data,
    input  wire                             pay_ready,
    output logic                            hdr_valid,
    output udp_parser_pkg::udp_hdr_t        hdr
);

    import udp_parser_pkg::*;

    offset_t  offset;
    offset_t  payload_end;
    udp_hdr_t fields;
    logic     accept;
    logic     in_payload;
    logic     hdr_done;

    function automatic logic in_range(offset_t off, int unsigned lo, int unsigned len);
        return (off >= offset_t'(lo)) && (off < offset_t'(lo + len));
    endfunction

    assign in_payload = offset >= offset_t'(`PAYLOAD_OFFSET);

    // only payload bytes can be held back by the buffer
    assign beat_ready = in_payload ? pay_ready : 1'b1;
    assign accept     = beat_valid && beat_ready;

    // udp length counts the udp header, so the end is relative to UDP_OFFSET
    assign payload_end = offset_t'(`UDP_OFFSET) + fields.udp_length;
    assign frame_end   = accept
                       && (offset >= offset_t'(`PAYLOAD_OFFSET - 1))
                       && (offset == payload_end - 1'b1);
    assign hdr_done    = accept && (offset == offset_t'(`PAYLOAD_OFFSET - 1));

    assign pay_valid = beat_valid && in_payload;
    assign pay_data  = beat_data;

    always_comb begin
        csum_beat.valid    = accept && ((offset == offset_t'(`IP_PROTO_OFFSET))
                                        || (offset >= offset_t'(`IP_SRC_OFFSET)));
        csum_beat.data     = beat_data;
        // protocol sits at an odd offset, so parity puts it in the low lane too
        csum_beat.low_lane = offset[0];
        csum_beat.twice    = in_range(offset, `UDP_OFFSET + 4, 2);
        csum_beat.last     = frame_end;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            offset    <= '0;
            hdr_valid <= 1'b0;
        end else begin
            hdr_valid <= hdr_done;
            if (frame_end) begin
                offset <= '0;
            end else if (accept) begin
                offset <= offset + 1'b1;
            end
        end
    end

    // fields shift in msb first as their bytes go by
    always_ff @(posedge clock) begin
        if (accept) begin
            if (in_range(offset, `IP_SRC_OFFSET, 4)) begin
                fields.ip_src <= {fields.ip_src[23:0], beat_data};
            end
            if (in_range(offset, `IP_DST_OFFSET, 4)) begin
                fields.ip_dst <= {fields.ip_dst[23:0], beat_data};
            end
            if (in_range(offset, `UDP_OFFSET, 2)) begin
                fields.src_port <= {fields.src_port[7:0], beat_data};
            end
            if (in_range(offset, `UDP_OFFSET + 2, 2)) begin
                fields.dst_port <= {fields.dst_port[7:0], beat_data};
            end
            if (in_range(offset, `UDP_OFFSET + 4, 2)) begin
                fields.udp_length <= {fields.udp_length[7:0], beat_data};
            end
        end
        if (hdr_done) begin
            hdr <= fields;
        end
    end

    // a shorter length would end the frame inside the udp header
    assert property (@(posedge clock) disable iff (reset)
        hdr_valid |-> hdr.udp_length >= 16'(`UDP_HDR_BYTES))
        else $error("udp length below the udp header size");

endmodule

`default_nettype wire

// ==== rtl/payload_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "udp_parser_defines.svh"

module payload_fifo #(
    parameter int DEPTH = `PAYLOAD_FIFO_DEPTH
) (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         pay_valid,
    input  wire udp_parser_pkg::byte_t  pay_data,
    output logic                        pay_ready,
    input  wire                         out_full,
    output logic                        out_wr_en,
    output udp_parser_pkg::byte_t       out_data
);

    import udp_parser_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    byte_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pay_ready = count != CNT_W'(DEPTH);
    assign wr_en     = pay_valid && pay_ready;
    // drain whenever downstream has room
    assign out_wr_en = (count != '0) && !out_full;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (out_wr_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, out_wr_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= pay_data;
        end
    end

    // equal pointers mean empty or full, and the count has to agree
    assert property (@(posedge clock) disable iff (reset)
        wr_en && (wr_ptr == rd_ptr) |-> count == '0)
        else $error("payload buffer written while full");

    assert property (@(posedge clock) disable iff (reset)
        out_wr_en && (wr_ptr == rd_ptr) |-> count == CNT_W'(DEPTH))
        else $error("payload buffer read while empty");

endmodule

`default_nettype wire

// ==== rtl/udp_checksum.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "udp_parser_defines.svh"

module udp_checksum (
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire udp_parser_pkg::csum_beat_t     csum_beat,
    output logic                                status_valid,
    output udp_parser_pkg::frame_status_t       status
);

    import udp_parser_pkg::*;

    // protocol, both addresses, udp header
    localparam int HDR_BEATS = 1 + 8 + `UDP_HDR_BYTES;

    logic [31:0] acc;
    logic [31:0] acc_next;
    logic [31:0] addend;
    logic [16:0] fold_once;
    logic [15:0] folded;
    offset_t     beats;
    logic        closing;

    assign closing = csum_beat.valid && csum_beat.last;

    always_comb begin
        if (csum_beat.low_lane) begin
            addend = {24'b0, csum_beat.data};
        end else begin
            addend = {16'b0, csum_beat.data, 8'b0};
        end
        if (csum_beat.twice) begin
            addend = addend << 1;
        end
        acc_next  = acc + addend;
        // two folds are enough for a 32-bit sum
        fold_once = {1'b0, acc_next[31:16]} + {1'b0, acc_next[15:0]};
        folded    = fold_once[15:0] + {15'b0, fold_once[16]};
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            acc          <= '0;
            beats        <= '0;
            status_valid <= 1'b0;
        end else begin
            status_valid <= closing;
            if (closing) begin
                acc   <= '0;
                beats <= '0;
            end else if (csum_beat.valid) begin
                acc   <= acc_next;
                beats <= beats + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (closing) begin
            status.checksum_ok   <= folded == `CSUM_GOOD;
            status.payload_bytes <= beats + 1'b1 - offset_t'(HDR_BEATS);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/udp_parser.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "udp_parser_defines.svh"

module udp_parser (
    input  wire                             clock,
    input  wire                             reset,
    input  wire udp_parser_pkg::byte_t      in_data,
    input  wire                             in_sof,
    input  wire                             in_eof,
    input  wire                             in_empty,
    output logic                            in_rd_en,
    input  wire                             out_full,
    output logic                            out_wr_en,
    output udp_parser_pkg::byte_t           out_data,
    output logic                            hdr_valid,
    output udp_parser_pkg::udp_hdr_t        hdr,
    output logic                            status_valid,
    output udp_parser_pkg::frame_status_t   status
);

    import udp_parser_pkg::*;

    logic       beat_valid;
    logic       beat_ready;
    byte_t      beat_data;
    logic       frame_end;
    csum_beat_t csum_beat;
    logic       pay_valid;
    logic       pay_ready;
    byte_t      pay_data;

    frame_reader i_frame_reader (
        .clock      (clock),
        .reset      (reset),
        .in_data    (in_data),
        .in_sof     (in_sof),
        .in_eof     (in_eof),
        .in_empty   (in_empty),
        .in_rd_en   (in_rd_en),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_ready (beat_ready),
        .frame_end  (frame_end)
    );

    header_extractor i_header_extractor (
        .clock      (clock),
        .reset      (reset),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_ready (beat_ready),
        .frame_end  (frame_end),
        .csum_beat  (csum_beat),
        .pay_valid  (pay_valid),
        .pay_data   (pay_data),
        .pay_ready  (pay_ready),
        .hdr_valid  (hdr_valid),
        .hdr        (hdr)
    );

    udp_checksum i_udp_checksum (
        .clock        (clock),
        .reset        (reset),
        .csum_beat    (csum_beat),
        .status_valid (status_valid),
        .status       (status)
    );

    payload_fifo #(
        .DEPTH (`PAYLOAD_FIFO_DEPTH)
    ) i_payload_fifo (
        .clock     (clock),
        .reset     (reset),
        .pay_valid (pay_valid),
        .pay_data  (pay_data),
        .pay_ready (pay_ready),
        .out_full  (out_full),
        .out_wr_en (out_wr_en),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== rtl/udp_parser_defines.svh ====
`ifndef UDP_PARSER_DEFINES_SVH
`define UDP_PARSER_DEFINES_SVH

// header sizes in bytes, no IP options
`define ETH_HDR_BYTES 14
`define IP_HDR_BYTES 20
`define UDP_HDR_BYTES 8

// byte offsets counted from the sof byte
`define IP_PROTO_OFFSET 23
`define IP_SRC_OFFSET 26
`define IP_DST_OFFSET 30
`define UDP_OFFSET (`ETH_HDR_BYTES + `IP_HDR_BYTES)
`define PAYLOAD_OFFSET (`UDP_OFFSET + `UDP_HDR_BYTES)

// folded sum over a frame with a correct checksum
`define CSUM_GOOD 16'hffff

// payload buffer depth in bytes
`define PAYLOAD_FIFO_DEPTH 16

`endif

// ==== rtl/udp_parser_pkg.sv ====
`default_nettype none

package udp_parser_pkg;

    typedef logic [7:0] byte_t;

    // byte position inside a frame
    typedef logic [15:0] offset_t;

    typedef struct packed {
        logic [31:0] ip_src;
        logic [31:0] ip_dst;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_length;
    } udp_hdr_t;

    // one byte of the checksum stream
    typedef struct packed {
        logic  valid;
        byte_t data;
        logic  low_lane;   // low byte of a 16-bit word
        logic  twice;      // pseudo-header length reuses the udp length
        logic  last;
    } csum_beat_t;

    typedef struct packed {
        logic    checksum_ok;
        offset_t payload_bytes;
    } frame_status_t;

endpackage

`default_nettype wire

// ==== tests/tb_udp_parser.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_udp_parser;

    import udp_parser_pkg::*;

    localparam int NUM_ROWS = 8;
    localparam int HDR_LEN = 42;

    // one table row per frame
    typedef struct packed {
        logic [31:0] ip_src;
        logic [31:0] ip_dst;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [7:0]  pay_len;
        logic        corrupt;
        logic [7:0]  idle;
        logic [7:0]  trailer;
    } frame_row_t;

    // one entry of the modelled input FIFO
    typedef struct packed {
        logic  sof;
        logic  eof;
        byte_t data;
    } in_byte_t;

    logic          clock;
    logic          reset;
    byte_t         in_data;
    logic          in_sof;
    logic          in_eof;
    logic          in_empty;
    logic          in_rd_en;
    logic          out_full;
    logic          out_wr_en;
    byte_t         out_data;
    logic          hdr_valid;
    udp_hdr_t      hdr;
    logic          status_valid;
    frame_status_t status;

    frame_row_t    rows [NUM_ROWS];
    in_byte_t      in_queue [$];
    udp_hdr_t      exp_hdr [$];
    frame_status_t exp_status [$];
    byte_t         exp_bytes [$];
    logic [31:0]   lfsr_state;
    int            hdr_errors;
    int            status_errors;
    int            data_errors;
    int            other_errors;

    udp_parser i_udp_parser (
        .clock        (clock),
        .reset        (reset),
        .in_data      (in_data),
        .in_sof       (in_sof),
        .in_eof       (in_eof),
        .in_empty     (in_empty),
        .in_rd_en     (in_rd_en),
        .out_full     (out_full),
        .out_wr_en    (out_wr_en),
        .out_data     (out_data),
        .hdr_valid    (hdr_valid),
        .hdr          (hdr),
        .status_valid (status_valid),
        .status       (status)
    );

    always #50 clock = ~clock;

    // taps 32, 22, 2, 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic byte_t rand_byte();
        byte_t v;
        v = '0;
        for (int k = 0; k < 8; k++) begin
            v = {v[6:0], next_bit()};
        end
        return v;
    endfunction

    task automatic check_hdr(input udp_hdr_t got, input udp_hdr_t exp);
        if (got !== exp) begin
            hdr_errors++;
            $display("Fail at %0t: hdr is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_status(input frame_status_t got, input frame_status_t exp);
        if (got !== exp) begin
            status_errors++;
            $display("Fail at %0t: status is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("Fail at %0t: out_data is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic build_frame(input frame_row_t row);
        byte_t       head [HDR_LEN];
        byte_t       payload [$];
        byte_t       body [$];
        logic [15:0] udp_len;
        logic [31:0] acc;
        logic [15:0] csum;
        in_byte_t    b;
        int          i;
        udp_len = 16'd8 + 16'(row.pay_len);
        for (i = 0; i < row.pay_len; i++) begin
            payload.push_back(rand_byte());
        end
        // pseudo-header, udp header with zero checksum, payload padded to words
        acc = row.ip_src[31:16] + row.ip_src[15:0] + row.ip_dst[31:16] + row.ip_dst[15:0];
        acc = acc + 16'h0011 + udp_len + row.src_port + row.dst_port + udp_len;
        for (i = 0; i < row.pay_len; i += 2) begin
            acc = acc + {payload[i], (i + 1 < row.pay_len) ? payload[i + 1] : 8'h00};
        end
        acc = acc[31:16] + acc[15:0];
        acc = acc[31:16] + acc[15:0];
        csum = ~acc[15:0];
        if (row.corrupt) begin
            payload[row.pay_len / 2] = payload[row.pay_len / 2] ^ 8'h01;
        end
        for (i = 0; i < 12; i++) begin
            head[i] = 8'(8'h10 + i);
        end
        head[12] = 8'h08;
        head[13] = 8'h00;
        head[14] = 8'h45;
        head[15] = 8'h00;
        {head[16], head[17]} = 16'd20 + udp_len;
        for (i = 18; i < 22; i++) begin
            head[i] = 8'h00;
        end
        head[22] = 8'h40;
        head[23] = 8'h11;
        head[24] = 8'h00;
        head[25] = 8'h00;
        {head[26], head[27], head[28], head[29]} = row.ip_src;
        {head[30], head[31], head[32], head[33]} = row.ip_dst;
        {head[34], head[35]} = row.src_port;
        {head[36], head[37]} = row.dst_port;
        {head[38], head[39]} = udp_len;
        {head[40], head[41]} = csum;
        for (i = 0; i < row.idle; i++) begin
            in_queue.push_back('{sof: 1'b0, eof: 1'b0, data: rand_byte()});
        end
        for (i = 0; i < HDR_LEN; i++) begin
            body.push_back(head[i]);
        end
        for (i = 0; i < row.pay_len; i++) begin
            body.push_back(payload[i]);
            exp_bytes.push_back(payload[i]);
        end
        for (i = 0; i < row.trailer; i++) begin
            body.push_back(rand_byte());
        end
        for (i = 0; i < body.size(); i++) begin
            b.sof  = (i == 0);
            b.eof  = (i == body.size() - 1);
            b.data = body[i];
            in_queue.push_back(b);
        end
        exp_hdr.push_back('{ip_src: row.ip_src, ip_dst: row.ip_dst, src_port: row.src_port,
                            dst_port: row.dst_port, udp_length: udp_len});
        exp_status.push_back('{checksum_ok: !row.corrupt,
                               payload_bytes: offset_t'(row.pay_len)});
    endtask

    // one cycle of the modelled input FIFO and of the downstream full flag
    task automatic step_input();
        logic taken;
        logic gap;
        @(negedge clock);
        taken = in_rd_en && !in_empty;
        @(posedge clock);
        #10;
        if (taken) begin
            in_queue.delete(0);
        end
        gap = next_bit();
        gap = gap & next_bit();
        if (in_queue.size() != 0 && !gap) begin
            in_empty = 1'b0;
            in_sof   = in_queue[0].sof;
            in_eof   = in_queue[0].eof;
            in_data  = in_queue[0].data;
        end else begin
            in_empty = 1'b1;
            in_sof   = 1'b0;
            in_eof   = 1'b0;
            in_data  = '0;
        end
        out_full = next_bit();
    endtask

    // outputs are stable in the middle of the cycle
    always @(negedge clock) begin
        if (!reset) begin
            if (hdr_valid) begin
                if (exp_hdr.size() == 0) begin
                    other_errors++;
                    $display("header arrived with no frame left to match it");
                end else begin
                    check_hdr(hdr, exp_hdr.pop_front());
                end
            end
            if (status_valid) begin
                if (exp_status.size() == 0) begin
                    other_errors++;
                    $display("status arrived with no frame left to match it");
                end else begin
                    check_status(status, exp_status.pop_front());
                end
            end
            if (out_wr_en) begin
                if (exp_bytes.size() == 0) begin
                    other_errors++;
                    $display("payload byte %h written with none expected", out_data);
                end else begin
                    check_byte(out_data, exp_bytes.pop_front());
                end
            end
        end
    end

    initial begin
        int cycles;
        clock         = 1'b0;
        reset         = 1'b1;
        in_data       = '0;
        in_sof        = 1'b0;
        in_eof        = 1'b0;
        in_empty      = 1'b1;
        out_full      = 1'b0;
        lfsr_state    = 32'h19ee26eb;
        hdr_errors    = 0;
        status_errors = 0;
        data_errors   = 0;
        other_errors  = 0;
        // src, dst, sport, dport, payload, corrupt, idle, trailer
        rows[0] = '{32'hc0a80001, 32'hc0a80002, 16'd1234, 16'd53, 8'd0, 1'b0, 8'd3, 8'd0};
        rows[1] = '{32'h0a000001, 32'h0a0000fe, 16'd5000, 16'd7, 8'd1, 1'b0, 8'd0, 8'd4};
        rows[2] = '{32'hac100a01, 32'hac100a02, 16'hffff, 16'h0001, 8'd17, 1'b1, 8'd2, 8'd0};
        rows[3] = '{32'hffffffff, 32'h00000000, 16'd68, 16'd67, 8'd40, 1'b0, 8'd5, 8'd3};
        rows[4] = '{32'h7f000001, 32'h7f000001, 16'd9000, 16'd9001, 8'd24, 1'b0, 8'd0, 8'd0};
        rows[5] = '{32'hc6336401, 32'hcb007101, 16'd4444, 16'd5555, 8'd33, 1'b1, 8'd1, 8'd2};
        rows[6] = '{32'h01020304, 32'h05060708, 16'd161, 16'd162, 8'd6, 1'b0, 8'd0, 8'd1};
        rows[7] = '{32'h8d2a0011, 32'h8d2a00ff, 16'd123, 16'd321, 8'd29, 1'b0, 8'd4, 8'd0};
        for (int r = 0; r < NUM_ROWS; r++) begin
            build_frame(rows[r]);
        end

        repeat (2) @(posedge clock);
        #10;
        reset = 1'b0;

        cycles = 0;
        while (in_queue.size() != 0 && cycles < 20000) begin
            step_input();
            cycles++;
        end
        if (in_queue.size() != 0) begin
            other_errors++;
            $display("timeout: the DUT never read %0d input bytes", in_queue.size());
        end

        cycles = 0;
        while ((exp_hdr.size() + exp_status.size() + exp_bytes.size()) != 0
               && cycles < 4000) begin
            step_input();
            cycles++;
        end
        if (exp_hdr.size() != 0) begin
            other_errors++;
            $display("timeout: %0d headers never came", exp_hdr.size());
        end
        if (exp_status.size() != 0) begin
            other_errors++;
            $display("timeout: %0d status reports never came", exp_status.size());
        end
        if (exp_bytes.size() != 0) begin
            other_errors++;
            $display("timeout: %0d payload bytes never came out", exp_bytes.size());
        end

        // idle tail to catch stray outputs
        repeat (20) step_input();

        $display("errors: hdr %0d, status %0d, data %0d, other %0d",
                 hdr_errors, status_errors, data_errors, other_errors);
        if (hdr_errors + status_errors + data_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== udp_parser.f ====
+incdir+rtl
rtl/udp_parser_pkg.sv
rtl/frame_reader.sv
rtl/header_extractor.sv
rtl/udp_checksum.sv
rtl/payload_fifo.sv
rtl/udp_parser.sv
tests/tb_udp_parser.sv
